//--- tag_cache.f
+incdir+include
hdl/tag_cache_pkg.sv
hdl/l2_request_arb.sv
hdl/cache_lru.sv
hdl/l2_cache_tag.sv
hdl/l2_cache_hit_check.sv
hdl/l2_cache_tag_top.sv
test/l2_cache_tag_chk.sv
test/tb_l2_cache_tag.sv

//--- Makefile
# Verilator build and run for the L2 tag directory testbench

VERILATOR ?= verilator
TOP ?= tb_l2_cache_tag
FILELIST ?= tag_cache.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= Result: PASSED
SOURCES ?= $(shell grep -v '^+' $(FILELIST)) include/tag_cache_defs.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_l2_cache_tag.sv
//////////////////////////////////////////////////////////////////////
// L2 tag directory testbench: directed tests checked against a model
// of the tags, valid bits and pseudo-LRU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tag_cache_defs.svh"

module tb_l2_cache_tag;

	import tag_cache_pkg::*;

	localparam int TIMEOUT = 60;

	logic clk;
	logic reset;
	logic lookup_valid;
	logic lookup_ready;
	cache_req_t lookup_req;
	logic fill_valid;
	logic fill_ready;
	cache_req_t fill_req;
	logic resp_valid;
	logic resp_ready;
	cache_resp_t resp;

	logic [`L2_NUM_WAYS-1:0][`L2_TAG_WIDTH-1:0] tag_model [`L2_NUM_SETS];
	logic [`L2_NUM_WAYS-1:0] valid_model [`L2_NUM_SETS];
	logic [2:0] lru_model [`L2_NUM_SETS];	// Root, pair 0/1, pair 2/3
	cache_resp_t expected_q [$];
	cache_resp_t expected_resp;
	string test_name = "idle";
	int errors = 0;
	int timeouts = 0;
	int cycle = 0;
	int seed = 78980;
	logic [`L2_ID_WIDTH-1:0] next_id = '0;

	l2_cache_tag_top DUT
	(
		.clk(clk),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_ready(lookup_ready),
		.lookup_req(lookup_req),
		.fill_valid(fill_valid),
		.fill_ready(fill_ready),
		.fill_req(fill_req),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp(resp)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [1:0] victim(input logic [2:0] bits);
		if (bits[0])
			return bits[2] ? 2'd3 : 2'd2;
		return bits[1] ? 2'd1 : 2'd0;
	endfunction

	// Way is only defined for a hit
	function automatic bit resp_matches(input cache_resp_t exp, input cache_resp_t act);
		return exp.id == act.id && exp.op == act.op && exp.address == act.address
			&& exp.hit == act.hit && exp.replace_way == act.replace_way
			&& (!exp.hit || exp.way == act.way);
	endfunction

	// Requests take effect in acceptance order, so the model runs here
	task automatic accept(input cache_req_t req);
		cache_resp_t exp;
		logic [`L2_SET_INDEX_WIDTH-1:0] set;
		logic [`L2_TAG_WIDTH-1:0] tag;
		set = req.address[`L2_SET_INDEX_WIDTH-1:0];
		tag = req.address[`L2_ADDR_WIDTH-1:`L2_SET_INDEX_WIDTH];
		exp = '0;
		exp.id = req.id;
		exp.op = req.op;
		exp.address = req.address;
		exp.replace_way = victim(lru_model[set]);
		if (req.op == op_fill)
		begin
			tag_model[set][req.fill_way] = tag;
			valid_model[set][req.fill_way] = 1'b1;
			exp.hit = 1'b1;
			exp.way = req.fill_way;
		end
		else
			for (int w = 0; w < `L2_NUM_WAYS; w++)
				if (valid_model[set][w] && tag_model[set][w] == tag)
				begin
					exp.hit = 1'b1;
					exp.way = 2'(w);
				end
		if (exp.hit)
		begin
			lru_model[set][0] = exp.way < 2;	// Next victim in the other pair
			if (exp.way < 2)
				lru_model[set][1] = exp.way == 0;
			else
				lru_model[set][2] = exp.way == 2;
		end
		expected_q.push_back(exp);
	endtask

	task automatic end_run();
		int chk_errors;
		chk_errors = DUT.hit_check.resp_chk.failures;
		$display("Errors: %0d checks, %0d timeouts, %0d assertions", errors, timeouts,
			chk_errors);
		if (errors == 0 && timeouts == 0 && chk_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	task automatic send(input cache_op_t op, input logic [`L2_ADDR_WIDTH-1:0] address,
		input logic [1:0] way);
		cache_req_t req;
		int waited;
		req.op = op;
		req.id = next_id;
		req.address = address;
		req.fill_way = way;
		next_id++;
		if (op == op_fill)
		begin
			fill_req = req;
			fill_valid = 1'b1;
		end
		else
		begin
			lookup_req = req;
			lookup_valid = 1'b1;
		end
		waited = 0;
		@(negedge clk);
		while (!(op == op_fill ? fill_ready : lookup_ready) && waited < TIMEOUT)
		begin
			waited++;
			@(negedge clk);
		end
		if (waited >= TIMEOUT)
		begin
			$display("%s: %s request was never accepted", test_name,
				(op == op_fill) ? "fill" : "lookup");
			timeouts++;
			end_run();
		end
		else
		begin
			@(posedge clk);
			accept(req);
			#1;
			if (op == op_fill)
				fill_valid = 1'b0;
			else
				lookup_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (expected_q.size() != 0)
		begin
			$display("%s: %0d responses never arrived", test_name, expected_q.size());
			timeouts++;
			end_run();
		end
		else
			#1;
	endtask

	always @(negedge clk)
		if (!reset && resp_valid && resp_ready)
		begin
			if (expected_q.size() == 0)
			begin
				$display("%s: response with id %0d arrived unrequested", test_name, resp.id);
				errors++;
			end
			else
			begin
				expected_resp = expected_q.pop_front();
				if (!resp_matches(expected_resp, resp))
				begin
					$display("ERROR %s: expected %h, actual %h", test_name, expected_resp, resp);
					errors++;
				end
			end
		end

	task automatic reset_lookups();
		test_name = "reset_lookups";
		@(negedge clk);
		if (resp_valid || !lookup_ready || !fill_ready)
		begin
			$display("%s: handshake outputs are wrong after reset", test_name);
			errors++;
		end
		@(posedge clk);
		#1;
		repeat (8) send(op_lookup, `L2_ADDR_WIDTH'($random(seed)), 2'd0);
		drain();
	endtask

	task automatic fill_then_lookup();
		test_name = "fill_then_lookup";
		send(op_fill, {8'h5a, 4'h3}, 2'd2);
		send(op_lookup, {8'h5a, 4'h3}, 2'd0);
		send(op_lookup, {8'ha5, 4'h3}, 2'd0);	// Same set, other tag
		drain();
	endtask

	task automatic fill_victim_order();
		test_name = "fill_victim_order";
		for (int i = 0; i < 4; i++)
			send(op_fill, {8'h10 + 8'(i), 4'h7}, victim(lru_model[7]));
		for (int i = 0; i < 4; i++)
			send(op_lookup, {8'h10 + 8'(i), 4'h7}, 2'd0);
		drain();
	endtask

	task automatic backpressure();
		test_name = "backpressure";
		resp_ready = 1'b0;
		fork
			repeat (6) send(op_lookup, `L2_ADDR_WIDTH'($random(seed)), 2'd0);
			begin
				repeat (8) @(negedge clk);
				if (lookup_ready || fill_ready)
				begin
					$display("%s: input ready stayed high while responses were held", test_name);
					errors++;
				end
				@(posedge clk);
				#1;
				resp_ready = 1'b1;
			end
		join
		drain();
	endtask

	task automatic fill_lookup_together();
		test_name = "fill_lookup_together";
		fork
			send(op_fill, {8'hc3, 4'h9}, 2'd1);
			send(op_lookup, {8'hc3, 4'h9}, 2'd0);
			begin
				@(negedge clk);
				if (lookup_ready || !fill_ready)
				begin
					$display("%s: the fill did not win arbitration", test_name);
					errors++;
				end
			end
		join
		drain();
	endtask

	task automatic full_rate();
		int start;
		int waited;
		test_name = "full_rate";
		fork
			repeat (10) send(op_lookup, `L2_ADDR_WIDTH'($random(seed)), 2'd0);
			begin
				waited = 0;
				@(negedge clk);
				while (!(lookup_valid && lookup_ready) && waited < TIMEOUT)
				begin
					waited++;
					@(negedge clk);
				end
				start = cycle;	// Acceptance edge is the next one
				while (!resp_valid && waited < TIMEOUT)
				begin
					waited++;
					@(negedge clk);
				end
				if (waited >= TIMEOUT)
				begin
					$display("%s: no response appeared", test_name);
					timeouts++;
					end_run();
				end
				else
				begin
					if (cycle != start + 3)
					begin
						$display("ERROR %s: expected first response at cycle %0d, actual %0d",
							test_name, start + 3, cycle);
						errors++;
					end
					repeat (9)
					begin
						@(negedge clk);
						if (!resp_valid)
						begin
							$display("%s: gap in the response stream at cycle %0d",
								test_name, cycle);
							errors++;
						end
					end
				end
			end
		join
		drain();
	endtask

	initial
	begin
		reset = 1'b1;
		lookup_valid = 1'b0;
		lookup_req = '0;
		fill_valid = 1'b0;
		fill_req = '0;
		resp_ready = 1'b1;
		for (int s = 0; s < `L2_NUM_SETS; s++)
		begin
			tag_model[s] = '0;
			valid_model[s] = '0;
			lru_model[s] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		reset_lookups();
		fill_then_lookup();
		fill_victim_order();
		backpressure();
		fill_lookup_together();
		full_rate();
		end_run();
	end

endmodule

//--- test/l2_cache_tag_chk.sv
//////////////////////////////////////////////////////////////////////
// Response port assertions, bound into the hit check stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module l2_cache_tag_chk
(
	input clk,
	input reset,
	input resp_valid,
	input resp_ready,
	input tag_cache_pkg::cache_resp_t resp,
	input stall_pipeline
);

	import tag_cache_pkg::*;

	int failures = 0;	// Read by the testbench at the end of the run

	// A stalled response must neither move nor vanish
	stall_hold: assert property (@(posedge clk) disable iff (reset)
		stall_pipeline |=> $stable(resp) && resp_valid)
	else
	begin
		failures++;
		$error("response changed while the pipeline was stalled");
	end

	stall_rule: assert property (@(posedge clk) disable iff (reset)
		stall_pipeline == (resp_valid && !resp_ready))
	else
	begin
		failures++;
		$error("stall_pipeline does not follow resp_valid and resp_ready");
	end

	fill_hit: assert property (@(posedge clk) disable iff (reset)
		resp_valid && resp.op == op_fill |-> resp.hit)
	else
	begin
		failures++;
		$error("fill response without hit");
	end

endmodule

bind l2_cache_hit_check l2_cache_tag_chk resp_chk
(
	.clk(clk),
	.reset(reset),
	.resp_valid(resp_valid),
	.resp_ready(resp_ready),
	.resp(resp),
	.stall_pipeline(stall_pipeline)
);

//--- hdl/l2_cache_tag_top.sv
//////////////////////////////////////////////////////////////////////
// L2 tag directory top: arbiter, tag stage and hit check in a row
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module l2_cache_tag_top
(
	input clk,
	input reset,
	input lookup_valid,
	output logic lookup_ready,
	input tag_cache_pkg::cache_req_t lookup_req,
	input fill_valid,
	output logic fill_ready,
	input tag_cache_pkg::cache_req_t fill_req,
	output logic resp_valid,
	input resp_ready,
	output tag_cache_pkg::cache_resp_t resp
);

	import tag_cache_pkg::*;

	logic arb_valid;
	cache_req_t arb_req;
	logic tag_valid;
	tag_stage_t tag_out;
	logic stall_pipeline;

	l2_request_arb arb
	(
		.clk(clk),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_ready(lookup_ready),
		.lookup_req(lookup_req),
		.fill_valid(fill_valid),
		.fill_ready(fill_ready),
		.fill_req(fill_req),
		.stall_pipeline(stall_pipeline),
		.arb_valid(arb_valid),
		.arb_req(arb_req)
	);

	l2_cache_tag tag
	(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.arb_valid(arb_valid),
		.arb_req(arb_req),
		.tag_valid(tag_valid),
		.tag_out(tag_out)
	);

	l2_cache_hit_check hit_check
	(
		.clk(clk),
		.reset(reset),
		.tag_valid(tag_valid),
		.tag_out(tag_out),
		.resp_ready(resp_ready),
		.resp_valid(resp_valid),
		.resp(resp),
		.stall_pipeline(stall_pipeline)
	);

endmodule

//--- hdl/l2_cache_hit_check.sv
//////////////////////////////////////////////////////////////////////
// L2 hit check: tag compare, response register and pipeline stall
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tag_cache_defs.svh"

module l2_cache_hit_check
(
	input clk,
	input reset,
	input tag_valid,
	input tag_cache_pkg::tag_stage_t tag_out,
	input resp_ready,
	output logic resp_valid,
	output tag_cache_pkg::cache_resp_t resp,
	output logic stall_pipeline
);

	import tag_cache_pkg::*;

	logic is_fill;
	logic [`L2_NUM_WAYS-1:0] hits;
	cache_resp_t next_resp;

	// A held response freezes every stage behind it
	assign stall_pipeline = resp_valid && !resp_ready;

	assign is_fill = tag_out.req.op == op_fill;
	assign hits = stage_match(tag_out);

	always_comb
	begin
		next_resp.id = tag_out.req.id;
		next_resp.op = tag_out.req.op;
		next_resp.address = tag_out.req.address;
		next_resp.hit = is_fill || |hits;	// Fills report their own way
		next_resp.way = is_fill ? tag_out.req.fill_way : encode_way(hits);
		next_resp.replace_way = tag_out.replace_way;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resp_valid <= 1'b0;
			resp <= '0;
		end
		else if (!stall_pipeline)
		begin
			resp_valid <= tag_valid;
			resp <= next_resp;
		end
	end

endmodule

//--- hdl/l2_cache_tag.sv
//////////////////////////////////////////////////////////////////////
// L2 tag stage: reads the set's tags and valid bits, writes fills,
// and fetches the replacement way from the pseudo-LRU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tag_cache_defs.svh"

module l2_cache_tag
(
	input clk,
	input reset,
	input stall_pipeline,
	input arb_valid,
	input tag_cache_pkg::cache_req_t arb_req,
	output logic tag_valid,
	output tag_cache_pkg::tag_stage_t tag_out
);

	import tag_cache_pkg::*;

	logic [`L2_NUM_WAYS-1:0][`L2_TAG_WIDTH-1:0] tag_mem [`L2_NUM_SETS];
	logic [`L2_NUM_WAYS-1:0] valid_mem [`L2_NUM_SETS];

	logic [`L2_SET_INDEX_WIDTH-1:0] arb_set;
	logic [`L2_TAG_WIDTH-1:0] arb_tag;
	logic arb_is_fill;
	logic stage_is_fill;
	logic [`L2_NUM_WAYS-1:0] stage_hits;
	logic [`L2_WAY_WIDTH-1:0] lru_way;
	logic update_en;
	logic [`L2_SET_INDEX_WIDTH-1:0] update_set;
	logic [`L2_WAY_WIDTH-1:0] update_way;

	assign arb_set = arb_req.address[`L2_SET_INDEX_WIDTH-1:0];
	assign arb_tag = arb_req.address[`L2_ADDR_WIDTH-1:`L2_SET_INDEX_WIDTH];
	assign arb_is_fill = arb_valid && (arb_req.op == op_fill);

	// Local match feeds only the LRU, the response compare lives downstream
	assign stage_hits = stage_match(tag_out);
	assign stage_is_fill = tag_out.req.op == op_fill;

	// A miss leaves the LRU alone
	assign update_en = tag_valid && !stall_pipeline && (stage_is_fill || |stage_hits);
	assign update_set = tag_out.req.address[`L2_SET_INDEX_WIDTH-1:0];
	assign update_way = stage_is_fill ? tag_out.req.fill_way : encode_way(stage_hits);

	cache_lru lru
	(
		.clk(clk),
		.reset(reset),
		.read_set(arb_set),
		.update_en(update_en),
		.update_set(update_set),
		.update_way(update_way),
		.lru_way(lru_way)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tag_valid <= 1'b0;
			tag_out <= '0;
			for (int s = 0; s < `L2_NUM_SETS; s++)
			begin
				tag_mem[s] <= '0;
				valid_mem[s] <= '0;
			end
		end
		else if (!stall_pipeline)
		begin
			tag_valid <= arb_valid;
			tag_out.req <= arb_req;
			tag_out.tags <= tag_mem[arb_set];
			tag_out.valid <= valid_mem[arb_set];
			tag_out.replace_way <= lru_way;
			if (arb_is_fill)
			begin
				tag_mem[arb_set][arb_req.fill_way] <= arb_tag;	// Seen by the next request
				valid_mem[arb_set][arb_req.fill_way] <= 1'b1;
			end
		end
	end

endmodule

//--- hdl/cache_lru.sv
//////////////////////////////////////////////////////////////////////
// Tree pseudo-LRU, three bits per set, with same-set update forwarding
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tag_cache_defs.svh"

module cache_lru
(
	input clk,
	input reset,
	input [`L2_SET_INDEX_WIDTH-1:0] read_set,
	input update_en,
	input [`L2_SET_INDEX_WIDTH-1:0] update_set,
	input [`L2_WAY_WIDTH-1:0] update_way,
	output logic [`L2_WAY_WIDTH-1:0] lru_way
);

	// Bit 0 is the root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
	logic [`L2_NUM_WAYS-2:0] lru_bits [`L2_NUM_SETS];
	logic [`L2_NUM_WAYS-2:0] updated_bits;
	logic [`L2_NUM_WAYS-2:0] read_bits;

	// Point the tree away from the way just used
	function automatic logic [`L2_NUM_WAYS-2:0] touch(input logic [`L2_NUM_WAYS-2:0] bits,
		input logic [`L2_WAY_WIDTH-1:0] way);
		logic [`L2_NUM_WAYS-2:0] result;
		result = bits;
		result[0] = !way[1];
		if (way[1])
			result[2] = !way[0];
		else
			result[1] = !way[0];
		return result;
	endfunction

	assign updated_bits = touch(lru_bits[update_set], update_way);

	// Back-to-back requests to one set must see the pending update
	assign read_bits = (update_en && update_set == read_set) ? updated_bits
		: lru_bits[read_set];

	assign lru_way = read_bits[0] ? {1'b1, read_bits[2]} : {1'b0, read_bits[1]};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < `L2_NUM_SETS; s++)
				lru_bits[s] <= '0;
		end
		else if (update_en)
			lru_bits[update_set] <= updated_bits;
	end

endmodule

//--- hdl/l2_request_arb.sv
//////////////////////////////////////////////////////////////////////
// L2 request arbiter: picks a fill or a lookup and registers it,
// fills win when both are offered
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module l2_request_arb
(
	input clk,
	input reset,
	input lookup_valid,
	output logic lookup_ready,
	input tag_cache_pkg::cache_req_t lookup_req,
	input fill_valid,
	output logic fill_ready,
	input tag_cache_pkg::cache_req_t fill_req,
	input stall_pipeline,
	output logic arb_valid,
	output tag_cache_pkg::cache_req_t arb_req
);

	logic fill_take;
	logic lookup_take;

	// A waiting fill blocks the lookup stream for this cycle
	assign fill_ready = !stall_pipeline;
	assign lookup_ready = !stall_pipeline && !fill_valid;

	assign fill_take = fill_valid && fill_ready;
	assign lookup_take = lookup_valid && lookup_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			arb_valid <= 1'b0;
			arb_req <= '0;
		end
		else if (!stall_pipeline)
		begin
			arb_valid <= fill_take || lookup_take;
			if (fill_take)
				arb_req <= fill_req;
			else if (lookup_take)
				arb_req <= lookup_req;
		end
	end

endmodule

//--- hdl/tag_cache_pkg.sv
//////////////////////////////////////////////////////////////////////
// L2 tag directory types: requests, tag stage item, responses
//////////////////////////////////////////////////////////////////////

`include "tag_cache_defs.svh"

package tag_cache_pkg;

	typedef enum logic
	{
		op_lookup = 1'b0,
		op_fill = 1'b1
	} cache_op_t;

	typedef struct packed
	{
		cache_op_t op;
		logic [`L2_ID_WIDTH-1:0] id;
		logic [`L2_ADDR_WIDTH-1:0] address;
		logic [`L2_WAY_WIDTH-1:0] fill_way;	// Only meaningful for fills
	} cache_req_t;

	typedef struct packed
	{
		cache_req_t req;
		logic [`L2_NUM_WAYS-1:0][`L2_TAG_WIDTH-1:0] tags;
		logic [`L2_NUM_WAYS-1:0] valid;
		logic [`L2_WAY_WIDTH-1:0] replace_way;
	} tag_stage_t;

	typedef struct packed
	{
		logic [`L2_ID_WIDTH-1:0] id;
		cache_op_t op;
		logic [`L2_ADDR_WIDTH-1:0] address;
		logic hit;
		logic [`L2_WAY_WIDTH-1:0] way;
		logic [`L2_WAY_WIDTH-1:0] replace_way;
	} cache_resp_t;

	// One bit per way whose valid entry holds the request tag
	function automatic logic [`L2_NUM_WAYS-1:0] stage_match(input tag_stage_t stage);
		logic [`L2_NUM_WAYS-1:0] match;
		logic [`L2_TAG_WIDTH-1:0] req_tag;
		req_tag = stage.req.address[`L2_ADDR_WIDTH-1:`L2_SET_INDEX_WIDTH];
		for (int w = 0; w < `L2_NUM_WAYS; w++)
			match[w] = stage.valid[w] && (stage.tags[w] == req_tag);
		return match;
	endfunction

	function automatic logic [`L2_WAY_WIDTH-1:0] encode_way(input logic [`L2_NUM_WAYS-1:0] match);
		logic [`L2_WAY_WIDTH-1:0] way;
		way = '0;
		for (int w = 0; w < `L2_NUM_WAYS; w++)
			if (match[w])
				way = `L2_WAY_WIDTH'(w);
		return way;
	endfunction

endpackage

//--- include/tag_cache_defs.svh
//////////////////////////////////////////////////////////////////////
// L2 tag directory geometry: sets, ways, tag, line address and id
//////////////////////////////////////////////////////////////////////

`ifndef TAG_CACHE_DEFS_SVH
`define TAG_CACHE_DEFS_SVH

`define L2_NUM_SETS         16
`define L2_SET_INDEX_WIDTH  4
`define L2_NUM_WAYS         4
`define L2_WAY_WIDTH        2
`define L2_TAG_WIDTH        8

// Line address is the tag above the set index
`define L2_ADDR_WIDTH       12

`define L2_ID_WIDTH         4

`endif
